// ==== common/asrm_pkg.sv ====
/*
 * shared types and encodings for the asrm core. words are fixed at 16 bits.
 * an instruction sits in the low byte of a RAM word. class-0 bytes are full
 * opcodes, so call always jumps to r3, the register its low nibble names.
 */
package asrm_pkg;

    typedef logic [15:0] word_t;     // data and address word
    typedef logic [3:0]  reg_idx_t;  // 16 registers, r0 is the working register
    typedef logic [7:0]  instr_t;

    // operand classes, high nibble of the instruction
    localparam logic [3:0] opp_load = 4'h1;  // r0 <= mem[r[n]]
    localparam logic [3:0] opp_str  = 4'h2;  // mem[r[n]] <= r0
    localparam logic [3:0] opp_set  = 4'h3;  // r0 <= n
    localparam logic [3:0] opp_mov  = 4'h4;  // r[n] <= r0
    localparam logic [3:0] opp_add  = 4'h5;
    localparam logic [3:0] opp_sub  = 4'h6;
    localparam logic [3:0] opp_and  = 4'h7;
    localparam logic [3:0] opp_xor  = 4'h8;
    localparam logic [3:0] opp_shl  = 4'h9;  // r0 <= r0 << n
    localparam logic [3:0] opp_jmp  = 4'ha;  // pc <= r[n]

    // class-0 instructions, whole byte
    localparam instr_t inst_nop  = 8'h00;
    localparam instr_t inst_push = 8'h01;  // mem[sp] <= r0, sp--
    localparam instr_t inst_pop  = 8'h02;  // r0 <= mem[sp+1], sp++
    localparam instr_t inst_call = 8'h03;  // push return pc, pc <= r3
    localparam instr_t inst_ret  = 8'h04;  // pc <= mem[sp+1], sp++
    localparam instr_t inst_halt = 8'h0f;
    // any other class-0 byte, and classes b..f, behave as nop

    typedef enum logic [1:0] {
        sp_none = 2'd0,
        sp_inc  = 2'd1,
        sp_dec  = 2'd2
    } sp_step_t;

    // one-cycle result strobe from an execution unit
    typedef struct packed {
        logic     valid;
        logic     wr_en;      // write value into r[dest]
        reg_idx_t dest;
        word_t    value;
        logic     pc_load;    // redirect pc, overrides the fetch increment
        word_t    pc_target;
    } unit_result_t;

    // memory unit result also moves the stack pointer
    typedef struct packed {
        unit_result_t res;
        sp_step_t     sp_step;
    } mem_result_t;

    // architectural view that commit hands to both units
    typedef struct packed {
        word_t r0;
        word_t r_sel;  // r[n] for the low nibble of the current instruction
        word_t pc;     // already points past the current instruction
        word_t sp;     // next free stack slot
    } core_state_t;

    // true for every instruction that owns a RAM window
    function automatic logic is_mem_instr(instr_t i);
        return i == inst_push || i == inst_pop || i == inst_call || i == inst_ret
            || i[7:4] == opp_load || i[7:4] == opp_str;
    endfunction

endpackage

// ==== asrm_addr/asrm_addr.sv ====
/*
 * owns the instruction register and the RAM port. RAM read data must be valid in
 * the cycle of the address. a memory instruction holds the bus for ram_wait >= 1
 * cycles plus one idle fetch slot. sp and pc are moved by commit, not here.
 */
`timescale 1ns/1ps

module asrm_addr
    import asrm_pkg::*;
#(
    parameter int unsigned ram_wait = 2  // bus cycles per memory access
)(
    input  logic        clk,
    input  logic        reset,
    input  core_state_t core_state,
    input  logic        pc_hold,     // from commit, low on fetch cycles
    output word_t       ram_addr,
    output word_t       ram_wdata,
    output logic        ram_we,
    input  word_t       ram_rdata,
    output instr_t      instr,
    output mem_result_t mem_res,
    output logic        halted
);

    localparam int unsigned busy_w = $clog2(ram_wait + 1);
    localparam logic [busy_w-1:0] busy_last = busy_w'(ram_wait - 1);

    logic [busy_w-1:0] busy;  // cycle index inside a memory window
    logic [3:0] opp;
    logic       is_reg_acc;   // load/str, addressed by r[n]
    logic       is_stack_wr;  // push/call, addressed by sp
    logic       is_stack_rd;  // pop/ret, addressed by sp+1
    logic       is_write;
    logic       in_window;
    logic       last_cycle;

    assign opp         = instr[7:4];
    assign is_reg_acc  = opp == opp_load || opp == opp_str;
    assign is_stack_wr = instr == inst_push || instr == inst_call;
    assign is_stack_rd = instr == inst_pop || instr == inst_ret;
    assign is_write    = opp == opp_str || is_stack_wr;
    assign in_window   = is_mem_instr(instr);
    assign last_cycle  = in_window && busy == busy_last;

    // address mux, pc whenever no data access is pending
    always_comb
    begin
        if (is_reg_acc)
            ram_addr = core_state.r_sel;
        else if (is_stack_wr)
            ram_addr = core_state.sp;          // sp is the next free slot
        else if (is_stack_rd)
            ram_addr = core_state.sp + 16'd1;  // top of stack sits one above
        else
            ram_addr = core_state.pc;
    end

    always_comb
    begin
        if (instr == inst_call)
            ram_wdata = core_state.pc;  // pc already points past the call
        else if (is_write)
            ram_wdata = core_state.r0;
        else
            ram_wdata = '0;
    end

    // single write pulse at the start of the window, address held after it
    assign ram_we = is_write && busy == '0;

    // result strobe on the last window cycle, data taken straight from RAM
    always_comb
    begin
        mem_res           = '0;
        mem_res.res.valid = last_cycle;
        mem_res.res.dest  = '0;         // loads and pops only target r0
        mem_res.res.value = ram_rdata;
        mem_res.sp_step   = sp_none;
        if (opp == opp_load || instr == inst_pop)
            mem_res.res.wr_en = 1'b1;
        if (instr == inst_call)
        begin
            mem_res.res.pc_load   = 1'b1;
            mem_res.res.pc_target = core_state.r_sel;
        end
        else if (instr == inst_ret)
        begin
            mem_res.res.pc_load   = 1'b1;
            mem_res.res.pc_target = ram_rdata;  // popped return address
        end
        if (is_stack_wr)
            mem_res.sp_step = sp_dec;
        else if (is_stack_rd)
            mem_res.sp_step = sp_inc;
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            instr  <= inst_nop;  // first edge fetches from pc 0
            busy   <= '0;        // window counter starts idle
            halted <= 1'b0;
        end
        else
        begin
            if (instr == inst_halt)
                halted <= 1'b1;  // ir keeps halt, so this sticks
            if (in_window)
            begin
                if (last_cycle)
                begin
                    busy  <= '0;
                    instr <= inst_nop;  // idle slot, next fetch uses the new pc
                end
                else
                begin
                    busy <= busy + 1'b1;
                end
            end
            else if (!pc_hold)
            begin
                if (opp == opp_jmp)
                    instr <= inst_nop;         // byte behind a jmp is off path
                else
                    instr <= ram_rdata[7:0];   // instruction in the low byte
            end
        end
    end

endmodule

// ==== src/asrm_alu.sv ====
/*
 * combinational unit for set, mov, arithmetic, shift and jmp.
 * strobes valid for every instruction that owns no RAM window and is not halt.
 */
`timescale 1ns/1ps

module asrm_alu
    import asrm_pkg::*;
(
    input  instr_t       instr,
    input  core_state_t  core_state,
    output unit_result_t alu_res
);

    logic [3:0] opp;
    reg_idx_t   n;
    word_t      r0;
    word_t      r_sel;

    assign opp   = instr[7:4];
    assign n     = instr[3:0];
    assign r0    = core_state.r0;
    assign r_sel = core_state.r_sel;

    always_comb
    begin
        alu_res           = '0;
        alu_res.valid     = !is_mem_instr(instr) && instr != inst_halt;
        alu_res.dest      = '0;     // r0 unless mov says otherwise
        alu_res.pc_target = r_sel;  // used by jmp only
        case (opp)
            opp_set:
            begin
                alu_res.wr_en = 1'b1;
                alu_res.value = {12'h000, n};  // zero extended immediate
            end
            opp_mov:
            begin
                alu_res.wr_en = 1'b1;
                alu_res.dest  = n;
                alu_res.value = r0;
            end
            opp_add:
            begin
                alu_res.wr_en = 1'b1;
                alu_res.value = r0 + r_sel;  // wraps at 16 bits
            end
            opp_sub:
            begin
                alu_res.wr_en = 1'b1;
                alu_res.value = r0 - r_sel;
            end
            opp_and:
            begin
                alu_res.wr_en = 1'b1;
                alu_res.value = r0 & r_sel;
            end
            opp_xor:
            begin
                alu_res.wr_en = 1'b1;
                alu_res.value = r0 ^ r_sel;
            end
            opp_shl:
            begin
                alu_res.wr_en = 1'b1;
                alu_res.value = r0 << n;  // shift count is the immediate
            end
            opp_jmp:
                alu_res.pc_load = 1'b1;
            default:
                ;  // nop and unused bytes just let pc advance
        endcase
    end

endmodule

// ==== src/asrm_commit.sv ====
/*
 * register file, pc and sp. applies whichever unit strobes valid on that edge;
 * the two units never strobe together. sp resets to stack_top and grows down.
 */
`timescale 1ns/1ps

module asrm_commit
    import asrm_pkg::*;
#(
    parameter word_t stack_top = 16'h00ff
)(
    input  logic         clk,
    input  logic         reset,
    input  instr_t       instr,
    input  unit_result_t alu_res,
    input  mem_result_t  mem_res,
    output core_state_t  core_state,
    output logic         pc_hold
);

    word_t        regs [16];
    word_t        pc;
    word_t        sp;
    unit_result_t res;  // the strobe being applied this cycle

    // memory unit owns the cycle while its instruction sits in ir
    assign res = alu_res.valid ? alu_res : mem_res.res;

    // pc frozen for a whole RAM window, the redirect of call/ret lands with
    // mem_res on its last cycle; halt freezes it for good
    assign pc_hold = is_mem_instr(instr) || instr == inst_halt;

    assign core_state = '{
        r0:    regs[0],
        r_sel: regs[instr[3:0]],  // read port follows the current low nibble
        pc:    pc,
        sp:    sp
    };

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            for (int i = 0; i < 16; i++)
                regs[i] <= '0;
            pc <= '0;         // first fetch from address 0
            sp <= stack_top;
        end
        else
        begin
            if (res.valid && res.wr_en)
                regs[res.dest] <= res.value;

            // redirect beats the fetch increment
            if (res.valid && res.pc_load)
                pc <= res.pc_target;
            else if (!pc_hold)
                pc <= pc + 16'd1;

            if (mem_res.res.valid)
            begin
                case (mem_res.sp_step)
                    sp_inc:  sp <= sp + 16'd1;  // pop and ret
                    sp_dec:  sp <= sp - 16'd1;  // push and call
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== src/asrm_core.sv ====
/*
 * accumulator core top. RAM is external: combinational read, write at the edge
 * where ram_we is high. halted rises one cycle after halt reaches ir and holds
 * until reset.
 */
`timescale 1ns/1ps

module asrm_core
    import asrm_pkg::*;
#(
    parameter int unsigned ram_wait  = 2,          // >= 1
    parameter word_t       stack_top = 16'h00ff
)(
    input  logic  clk,
    input  logic  reset,
    output word_t ram_addr,
    output word_t ram_wdata,
    output logic  ram_we,
    input  word_t ram_rdata,
    output logic  halted
);

    instr_t       instr;       // current instruction byte
    core_state_t  core_state;
    unit_result_t alu_res;
    mem_result_t  mem_res;
    logic         pc_hold;

    // RAM traffic and the instruction register
    asrm_addr #(
        .ram_wait   (ram_wait)
    ) u_addr (
        .clk        (clk),
        .reset      (reset),
        .core_state (core_state),
        .pc_hold    (pc_hold),
        .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata),
        .ram_we     (ram_we),
        .ram_rdata  (ram_rdata),
        .instr      (instr),
        .mem_res    (mem_res),
        .halted     (halted)
    );

    asrm_alu u_alu (
        .instr      (instr),
        .core_state (core_state),
        .alu_res    (alu_res)
    );

    // architectural state, merges both strobes
    asrm_commit #(
        .stack_top  (stack_top)
    ) u_commit (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .alu_res    (alu_res),
        .mem_res    (mem_res),
        .core_state (core_state),
        .pc_hold    (pc_hold)
    );

endmodule

// ==== tb/asrm_tb_mem.sv ====
/*
 * behavioral RAM for the core testbench. full 64k words, combinational read,
 * write at the rising edge where we is high. fill() sets an address based pattern.
 */
`timescale 1ns/1ps

module asrm_tb_mem
    import asrm_pkg::*;
(
    input  logic  clk,
    input  word_t addr,
    input  word_t wdata,
    input  logic  we,
    output word_t rdata
);

    word_t mem [65536];

    assign rdata = mem[addr];  // same cycle read

    always @(posedge clk)
    begin
        if (we)
            mem[addr] <= wdata;
    end

    // background pattern, every word differs from its neighbours
    task automatic fill();
        int i;
        for (i = 0; i < 65536; i++)
            mem[i] = word_t'(i) ^ 16'hc35a;
    endtask

    task automatic poke(input word_t a, input word_t d);
        mem[a] = d;
    endtask

endmodule

// ==== tb/asrm_core_assert.sv ====
/*
 * protocol checks bound into asrm_core. a failure bumps fail_count,
 * which the testbench reads at the end of the run.
 */
`timescale 1ns/1ps

module asrm_core_assert
    import asrm_pkg::*;
(
    input logic         clk,
    input logic         reset,
    input unit_result_t alu_res,
    input mem_result_t  mem_res,
    input instr_t       instr,
    input word_t        ram_addr,
    input word_t        ram_wdata,
    input logic         ram_we,
    input logic         halted
);

    int fail_count = 0;

    // only one unit may own a cycle
    a_one_strobe: assert property (@(posedge clk) disable iff (!reset)
        !(alu_res.valid && mem_res.res.valid))
    else
    begin
        fail_count++;
        $error("alu and memory unit strobed valid in the same cycle");
    end

    a_no_write_halted: assert property (@(posedge clk) disable iff (!reset)
        !(halted && ram_we))
    else
    begin
        fail_count++;
        $error("ram_we high while halted");
    end

    // bus held steady until the window's last cycle
    a_window_stable: assert property (@(posedge clk) disable iff (!reset)
        (is_mem_instr(instr) && !mem_res.res.valid)
            |=> ($stable(ram_addr) && $stable(ram_wdata)))
    else
    begin
        fail_count++;
        $error("ram_addr or ram_wdata moved inside a memory window");
    end

endmodule

// ==== tb/asrm_tb.sv ====
/*
 * table driven testbench for asrm_core. each row builds a small program at
 * address 0 with its data, runs it to halt and compares every RAM write
 * with a list worked out from the instruction rules. ram_wait 3, stack at 0xf0.
 */
`timescale 1ns/1ps

module asrm_tb
    import asrm_pkg::*;
();

    localparam int unsigned ram_wait     = 3;
    localparam word_t       stack_top    = 16'h00f0;
    localparam int          num_rows     = 16;
    localparam int          max_prog_len = 35;  // call program incl. subroutine
    localparam int          timeout_cyc  = num_rows * (max_prog_len * (ram_wait + 2) + 10);

    typedef enum logic [3:0] {
        t_add, t_sub, t_and, t_xor, t_shl, t_setmov, t_stack, t_call
    } test_kind_t;

    typedef struct packed {
        test_kind_t kind;
        logic       rnd;  // operands taken from the lfsr
        word_t      a;
        word_t      b;
        word_t      exp;  // arithmetic result for directed rows
    } row_t;

    logic        clk = 1'b0;
    logic        reset;
    word_t       ram_addr;
    word_t       ram_wdata;
    word_t       ram_rdata;
    logic        ram_we;
    logic        halted;
    logic [31:0] lfsr_state = 32'h4589_c019;
    word_t       exp_addr [$];
    word_t       exp_data [$];
    word_t       rec_addr [$];  // writes seen on the RAM port
    word_t       rec_data [$];
    int          value_errors = 0;
    int          count_errors = 0;
    int          late_writes  = 0;

    row_t test_table [num_rows] = '{
        '{t_add,    1'b0, 16'h1234, 16'h0f0f, 16'h2143},
        '{t_sub,    1'b0, 16'h0005, 16'h0007, 16'hfffe},  // borrow wraps
        '{t_and,    1'b0, 16'hf0f0, 16'h3c3c, 16'h3030},
        '{t_xor,    1'b0, 16'haaaa, 16'h0ff0, 16'ha55a},
        '{t_shl,    1'b0, 16'h8001, 16'h0004, 16'h0010},  // top bit lost
        '{t_add,    1'b0, 16'hffff, 16'h0002, 16'h0001},
        '{t_add,    1'b1, 16'h0000, 16'h0000, 16'h0000},
        '{t_xor,    1'b1, 16'h0000, 16'h0000, 16'h0000},
        '{t_shl,    1'b1, 16'h0000, 16'h0000, 16'h0000},
        '{t_sub,    1'b1, 16'h0000, 16'h0000, 16'h0000},
        '{t_setmov, 1'b0, 16'h0005, 16'h0009, 16'h0000},
        '{t_setmov, 1'b0, 16'h000f, 16'h0000, 16'h0000},
        '{t_stack,  1'b0, 16'h0003, 16'h000c, 16'h0000},
        '{t_stack,  1'b1, 16'h0000, 16'h0000, 16'h0000},
        '{t_call,   1'b0, 16'h0007, 16'h0000, 16'h0000},
        '{t_call,   1'b1, 16'h0000, 16'h0000, 16'h0000}
    };

    asrm_core #(
        .ram_wait  (ram_wait),
        .stack_top (stack_top)
    ) UUT (
        .clk       (clk),
        .reset     (reset),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_we    (ram_we),
        .ram_rdata (ram_rdata),
        .halted    (halted)
    );

    asrm_tb_mem u_mem (
        .clk   (clk),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .we    (ram_we),
        .rdata (ram_rdata)
    );

    bind asrm_core asrm_core_assert u_check (
        .clk       (clk),
        .reset     (reset),
        .alu_res   (alu_res),
        .mem_res   (mem_res),
        .instr     (instr),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_we    (ram_we),
        .halted    (halted)
    );

    always #5 clk = ~clk;  // 10 ns period

    // RAM port is stable at the falling edge, the write lands on the next rise
    always @(negedge clk)
    begin
        if (reset === 1'b1 && ram_we === 1'b1)
        begin
            rec_addr.push_back(ram_addr);
            rec_data.push_back(ram_wdata);
            assert (halted !== 1'b1)
            else
            begin
                late_writes++;
                $display("RAM write to %h at %0t came after halted rose", ram_addr, $time);
            end
        end
    end

    // taps 32,22,2,1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output word_t v);
        int i;
        v = '0;
        for (i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);  // one step per bit
            v = {v[14:0], lfsr_state[0]};
        end
    endtask

    function automatic word_t expected_alu(input test_kind_t k, input word_t a, input word_t b);
        case (k)
            t_add:   return a + b;
            t_sub:   return a - b;
            t_and:   return a & b;
            t_xor:   return a ^ b;
            t_shl:   return a << b[3:0];  // immediate shift count
            default: return '0;
        endcase
    endfunction

    function automatic instr_t encode(input logic [3:0] cls, input logic [3:0] n);
        return {cls, n};
    endfunction

    task automatic expect_write(input word_t addr, input word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    // program bytes at address 0 upward, data words and the expected writes
    task automatic build_program(input row_t row);
        instr_t prog [$];
        instr_t op_byte;
        word_t  a4;
        word_t  b4;
        int     i;
        a4 = {12'h000, row.a[3:0]};
        b4 = {12'h000, row.b[3:0]};
        case (row.kind)
            t_setmov:
            begin
                prog = {encode(opp_set, 4'h2), encode(opp_shl, 4'h4), encode(opp_mov, 4'h6),
                        encode(opp_set, row.a[3:0]), encode(opp_add, 4'h6),
                        encode(opp_mov, 4'h6), encode(opp_set, row.b[3:0]),
                        encode(opp_str, 4'h6), encode(opp_mov, 4'h9), encode(opp_set, 4'h3),
                        encode(opp_shl, 4'h4), encode(opp_add, 4'h9), encode(opp_mov, 4'ha),
                        encode(opp_str, 4'ha), inst_halt};
                expect_write(16'h0020 + a4, b4);          // r6 = 0x20 + a
                expect_write(16'h0030 + b4, 16'h0030 + b4);
            end
            t_stack:
            begin
                prog = {encode(opp_set, row.a[3:0]), inst_push,
                        encode(opp_set, row.b[3:0]), inst_push, encode(opp_shl, 4'h1),
                        inst_push, encode(opp_set, 4'h5), encode(opp_shl, 4'h4),
                        encode(opp_mov, 4'h8), encode(opp_set, 4'h1), encode(opp_add, 4'h8),
                        encode(opp_mov, 4'h9), encode(opp_set, 4'h2), encode(opp_add, 4'h8),
                        encode(opp_mov, 4'hb), inst_pop, encode(opp_str, 4'h8), inst_pop,
                        encode(opp_str, 4'h9), inst_pop, encode(opp_str, 4'hb), inst_halt};
                expect_write(stack_top, a4);              // pushes grow downward
                expect_write(stack_top - 16'd1, b4);
                expect_write(stack_top - 16'd2, b4 << 1);
                expect_write(16'h0050, b4 << 1);          // pops come back reversed
                expect_write(16'h0051, b4);
                expect_write(16'h0052, a4);
            end
            t_call:
            begin
                prog = {encode(opp_set, 4'h6), encode(opp_shl, 4'h4), encode(opp_mov, 4'h8),
                        encode(opp_set, 4'h1), encode(opp_add, 4'h8), encode(opp_mov, 4'h9),
                        encode(opp_set, 4'h2), encode(opp_add, 4'h8), encode(opp_mov, 4'ha),
                        encode(opp_set, 4'h2), encode(opp_shl, 4'h4), encode(opp_mov, 4'h3),
                        encode(opp_set, 4'hc), encode(opp_shl, 4'h1), encode(opp_mov, 4'hc),
                        encode(opp_set, row.a[3:0]), inst_call, encode(opp_str, 4'h9),
                        encode(opp_jmp, 4'hc), encode(opp_str, 4'ha)};
                while (prog.size() < 24)
                    prog.push_back(inst_nop);
                prog.push_back(inst_halt);              // jmp target, r12 = 24
                while (prog.size() < 32)
                    prog.push_back(inst_nop);
                prog.push_back(encode(opp_str, 4'h8));  // subroutine at r3 = 32
                prog.push_back(encode(opp_shl, 4'h1));
                prog.push_back(inst_ret);
                expect_write(stack_top, 16'd17);        // return address after the call
                expect_write(16'h0060, a4);
                expect_write(16'h0061, a4 << 1);        // store after ret; 0x62 never written
            end
            default:
            begin
                case (row.kind)
                    t_add:   op_byte = encode(opp_add, 4'h4);
                    t_sub:   op_byte = encode(opp_sub, 4'h4);
                    t_and:   op_byte = encode(opp_and, 4'h4);
                    t_xor:   op_byte = encode(opp_xor, 4'h4);
                    default: op_byte = encode(opp_shl, row.b[3:0]);
                endcase
                prog = {encode(opp_set, 4'h8), encode(opp_shl, 4'h4), encode(opp_mov, 4'h5),
                        encode(opp_set, 4'h4), encode(opp_shl, 4'h4), encode(opp_mov, 4'h1),
                        encode(opp_set, 4'h1), encode(opp_add, 4'h1), encode(opp_mov, 4'h2),
                        encode(opp_load, 4'h2), encode(opp_mov, 4'h4), encode(opp_load, 4'h1),
                        op_byte, encode(opp_str, 4'h5), inst_halt};
                u_mem.poke(16'h0040, row.a);  // operand a, then b
                u_mem.poke(16'h0041, row.b);
                expect_write(16'h0080, row.exp);
            end
        endcase
        for (i = 0; i < prog.size(); i++)
            u_mem.poke(word_t'(i), {8'h00, prog[i]});
    endtask

    task automatic check_row(input int idx);
        int n;
        int i;
        n = (rec_addr.size() < exp_addr.size()) ? rec_addr.size() : exp_addr.size();
        assert (rec_addr.size() == exp_addr.size())
        else
        begin
            count_errors++;
            $display("row %0d made %0d RAM writes where %0d were expected",
                     idx, rec_addr.size(), exp_addr.size());
        end
        for (i = 0; i < n; i++)
        begin
            assert (rec_addr[i] === exp_addr[i])
            else
            begin
                value_errors++;
                $display("** Error at %0t: ram_addr expected %h, actual %h (row %0d write %0d)",
                         $time, exp_addr[i], rec_addr[i], idx, i);
            end
            assert (rec_data[i] === exp_data[i])
            else
            begin
                value_errors++;
                $display("** Error at %0t: ram_wdata expected %h, actual %h (row %0d write %0d)",
                         $time, exp_data[i], rec_data[i], idx, i);
            end
        end
    endtask

    task automatic run_row(input int idx);
        row_t row;
        row = test_table[idx];
        if (row.rnd)
        begin
            if (row.kind == t_setmov || row.kind == t_stack || row.kind == t_call)
            begin
                take_bits(4, row.a);  // immediates are one nibble
                take_bits(4, row.b);
            end
            else
            begin
                take_bits(16, row.a);
                take_bits((row.kind == t_shl) ? 4 : 16, row.b);
                row.exp = expected_alu(row.kind, row.a, row.b);
            end
        end
        @(posedge clk);
        #1 reset = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        exp_addr.delete();
        exp_data.delete();
        rec_addr.delete();
        rec_data.delete();
        u_mem.fill();
        build_program(row);
        repeat (2) @(posedge clk);
        #1 reset = 1'b1;              // first fetch from address 0
        wait (halted === 1'b1);
        repeat (ram_wait + 2) @(posedge clk);  // room for a stray write to show
        check_row(idx);
    endtask

    initial
    begin
        int r;
        int assert_fails;
        reset = 1'b0;
        for (r = 0; r < num_rows; r++)
            run_row(r);
        assert_fails = UUT.u_check.fail_count;
        $display("errors: values %0d, write counts %0d, late writes %0d, assertions %0d",
                 value_errors, count_errors, late_writes, assert_fails);
        if (value_errors + count_errors + late_writes + assert_fails == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    // watchdog, every row must reach halt well inside this
    initial
    begin
        #(timeout_cyc * 10);
        $display("timeout after %0d cycles, halted never arrived", timeout_cyc);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== asrm_core.f ====
common/asrm_pkg.sv
asrm_addr/asrm_addr.sv
src/asrm_alu.sv
src/asrm_commit.sv
src/asrm_core.sv
tb/asrm_tb_mem.sv
tb/asrm_core_assert.sv
tb/asrm_tb.sv
